// ==== verilog/acq_pkg.sv ====
package acq_pkg;

   // ------------------------------
   // sizes
   // ------------------------------
   localparam int AXNUM         = 24;           // antennas, one bit per sample each
   localparam int BUF_AW        = 9;            // on-chip buffer address bits
   localparam int BUF_DEPTH     = 1 << BUF_AW;  // 512 entries
   localparam int MEM_AW        = 20;           // memory controller word address
   localparam int DAT_W         = 32;           // controller data width

   // samples per capture, deliberately more than the buffer holds
   localparam int CAPTURE_WORDS = 600;

   // ------------------------------
   // types
   // ------------------------------
   typedef logic [AXNUM-1:0]  sample_t;
   typedef logic [BUF_AW-1:0] buf_addr_t;

   // write command to the memory controller
   typedef struct packed {
      logic [MEM_AW-1:0] adr;  // word address, counts up from 0
      logic [DAT_W-1:0]  dat;  // sample, zero-extended
   } mem_cmd_t;

   // capture FSM
   typedef enum logic [2:0] {
      IDLE     = 3'd0,  // waiting for capture_i
      CAPTURE  = 3'd1,  // streaming buffer to memory
      DONE     = 3'd2,  // all words accepted
      OVERFLOW = 3'd3   // buffer wrapped onto unread data
   } acq_state_e;

endpackage

// ==== verilog/sample_buffer.sv ====
`timescale 1ns/1ps

// simple dual-port sample RAM
// write port follows the strobe, read port has one cycle latency
module sample_buffer (
   input  logic               clock_x,
   // write side
   input  logic               wr_en_i,
   input  acq_pkg::buf_addr_t wr_addr_i,
   input  acq_pkg::sample_t   wr_data_i,
   // read side
   input  acq_pkg::buf_addr_t rd_addr_i,
   output acq_pkg::sample_t   rd_data_o
);

   import acq_pkg::*;

   // ------------------------------
   // storage
   // ------------------------------
   sample_t mem [BUF_DEPTH];  // maps onto one block RAM

   always_ff @(posedge clock_x) begin
      if (wr_en_i) begin
         mem[wr_addr_i] <= wr_data_i;  // one sample per strobe
      end
   end

   // ------------------------------
   // registered read
   // ------------------------------
   // read before write on a shared address
   // the scheduler never reads a slot that is being written
   // unless the buffer has already overflowed
   always_ff @(posedge clock_x) begin
      rd_data_o <= mem[rd_addr_i];
   end

endmodule

// ==== verilog/burst_scheduler.sv ====
`timescale 1ns/1ps

// capture FSM and buffer-to-memory streamer
// pulls samples out of the buffer and presents them as write commands
module burst_scheduler (
   input  logic                clock_x,
   input  logic                rst_n_i,
   // control
   input  logic                capture_i,
   input  logic                request_i,
   input  logic                strobe_i,
   // buffer side
   input  acq_pkg::buf_addr_t  waddr_i,
   output acq_pkg::buf_addr_t  raddr_o,
   input  acq_pkg::sample_t    rdata_i,
   // memory controller
   output logic                mcb_ce_o,
   input  logic                mcb_rdy_i,
   output acq_pkg::mem_cmd_t   mcb_cmd_o,
   output acq_pkg::acq_state_e state_o
);

   import acq_pkg::*;

   typedef logic [MEM_AW-1:0] word_cnt_t;

   acq_state_e state;
   buf_addr_t  rptr;      // next entry to read
   buf_addr_t  fill;      // unread entries
   word_cnt_t  rd_cnt;    // reads issued this capture
   word_cnt_t  ld_cnt;    // commands loaded, also the next address
   word_cnt_t  ac_cnt;    // commands accepted
   logic       rd_pend;   // rdata holds a sample not yet loaded
   logic       start;
   logic       slot_free;
   logic       rd_en;
   logic       load;
   logic       accept;
   logic       last_acc;
   logic       ovf;

   // ------------------------------
   // datapath decisions
   // ------------------------------
   assign start     = (state == IDLE) && capture_i;
   assign fill      = waddr_i - rptr;              // wraps with the 9-bit pointers
   assign accept    = mcb_ce_o && mcb_rdy_i;       // transfer on this edge
   assign slot_free = !mcb_ce_o || mcb_rdy_i;      // command reg empty or emptying
   assign load      = rd_pend && slot_free;

   // read when data waits, the quota is open and the pipe can move
   assign rd_en = (state == CAPTURE) && (fill != '0) &&
                  (rd_cnt != word_cnt_t'(CAPTURE_WORDS)) &&
                  (!rd_pend || slot_free);

   // a strobe on a full buffer lands on the oldest unread slot
   assign ovf      = (state == CAPTURE) && strobe_i && (fill == '1);
   assign last_acc = accept && (ac_cnt == word_cnt_t'(CAPTURE_WORDS - 1));

   // hold the previous address while stalled so rdata stays put
   assign raddr_o = rd_en ? rptr : rptr - buf_addr_t'(1);
   assign state_o = state;

   // ------------------------------
   // capture FSM
   // ------------------------------
   always_ff @(posedge clock_x or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state <= IDLE;
      end else begin
         unique case (state)
            IDLE:     if (capture_i) state <= CAPTURE;
            CAPTURE: begin
               if (ovf) begin
                  state <= OVERFLOW;  // sample lost, stop streaming
               end else if (last_acc) begin
                  state <= DONE;
               end
            end
            DONE,
            OVERFLOW: if (request_i) state <= IDLE;  // host re-arms
            default:  state <= IDLE;
         endcase
      end
   end

   // ------------------------------
   // pointers and counters
   // ------------------------------
   always_ff @(posedge clock_x or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rptr   <= '0;
         rd_cnt <= '0;
         ld_cnt <= '0;
         ac_cnt <= '0;
      end else if (start) begin
         // a strobe on the start edge belongs to the previous epoch
         rptr   <= waddr_i + buf_addr_t'(strobe_i);
         rd_cnt <= '0;
         ld_cnt <= '0;
         ac_cnt <= '0;
      end else begin
         if (rd_en) begin
            rptr   <= rptr + buf_addr_t'(1);
            rd_cnt <= rd_cnt + word_cnt_t'(1);
         end
         if (load)   ld_cnt <= ld_cnt + word_cnt_t'(1);
         if (accept) ac_cnt <= ac_cnt + word_cnt_t'(1);
      end
   end

   // ------------------------------
   // command handshake
   // ------------------------------
   always_ff @(posedge clock_x or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rd_pend  <= 1'b0;
         mcb_ce_o <= 1'b0;
      end else if (ovf) begin
         rd_pend  <= 1'b0;
         mcb_ce_o <= 1'b0;  // drop the request outright
      end else begin
         rd_pend <= rd_en || (rd_pend && !slot_free);
         if (load) begin
            mcb_ce_o <= 1'b1;  // back to back when accepted same edge
         end else if (accept) begin
            mcb_ce_o <= 1'b0;
         end
      end
   end

   // payload only moves on load, so it is stable while stalled
   always_ff @(posedge clock_x) begin
      if (load) begin
         mcb_cmd_o.adr <= ld_cnt;
         mcb_cmd_o.dat <= DAT_W'(rdata_i);  // zero-extend the sample
      end
   end

endmodule

// ==== verilog/raw_acquire.sv ====
`timescale 1ns/1ps

// raw antenna capture
// samples go through the on-chip buffer and out as memory writes
module raw_acquire (
   input  logic                clock_x,
   input  logic                rst_n_i,
   // control
   input  logic                capture_i,
   input  logic                request_i,
   // sample input, no back-pressure
   input  logic                strobe_i,
   input  acq_pkg::sample_t    signal_i,
   // memory controller
   output logic                mcb_ce_o,
   input  logic                mcb_rdy_i,
   output acq_pkg::mem_cmd_t   mcb_cmd_o,
   output acq_pkg::acq_state_e state_o
);

   import acq_pkg::*;

   buf_addr_t waddr;  // next free entry
   buf_addr_t raddr;
   sample_t   rdata;

   // ------------------------------
   // write address
   // ------------------------------
   // free running, wraps at the buffer depth
   always_ff @(posedge clock_x or negedge rst_n_i) begin
      if (!rst_n_i) begin
         waddr <= '0;
      end else if (strobe_i) begin
         waddr <= waddr + buf_addr_t'(1);
      end
   end

   // ------------------------------
   // buffer and scheduler
   // ------------------------------
   sample_buffer u_buffer (
      .clock_x   (clock_x),
      .wr_en_i   (strobe_i),
      .wr_addr_i (waddr),
      .wr_data_i (signal_i),
      .rd_addr_i (raddr),
      .rd_data_o (rdata)     // one cycle after raddr
   );

   burst_scheduler u_scheduler (
      .clock_x   (clock_x),
      .rst_n_i   (rst_n_i),
      .capture_i (capture_i),
      .request_i (request_i),
      .strobe_i  (strobe_i),   // overflow check
      .waddr_i   (waddr),
      .raddr_o   (raddr),
      .rdata_i   (rdata),
      .mcb_ce_o  (mcb_ce_o),
      .mcb_rdy_i (mcb_rdy_i),
      .mcb_cmd_o (mcb_cmd_o),
      .state_o   (state_o)
   );

endmodule

// ==== verilog/acq_top.sv ====
`timescale 1ns/1ps

// ------------------------------
// acquisition top level
// ------------------------------
// the boundary seen by the testbench
// everything below runs on clock_x
module acq_top (
   input  logic                clock_x,
   input  logic                rst_n_i,

   // host control
   input  logic                capture_i,   // arm a capture from IDLE
   input  logic                request_i,   // re-arm from DONE or OVERFLOW

   // antenna samples
   input  logic                strobe_i,    // one sample per high cycle
   input  acq_pkg::sample_t    signal_i,

   // memory controller command port
   output logic                mcb_ce_o,    // held until mcb_rdy_i
   input  logic                mcb_rdy_i,
   output acq_pkg::mem_cmd_t   mcb_cmd_o,

   // status
   output acq_pkg::acq_state_e state_o
);

   // ------------------------------
   // core
   // ------------------------------
   raw_acquire u_acquire (
      .clock_x   (clock_x),
      .rst_n_i   (rst_n_i),

      // control
      .capture_i (capture_i),
      .request_i (request_i),

      // samples
      .strobe_i  (strobe_i),
      .signal_i  (signal_i),

      // command port
      .mcb_ce_o  (mcb_ce_o),
      .mcb_rdy_i (mcb_rdy_i),
      .mcb_cmd_o (mcb_cmd_o),

      // status
      .state_o   (state_o)
   );

endmodule

// ==== bench/mem_model.sv ====
`timescale 1ns/1ps

// memory controller stub
// random ready, held low the whole time stall_i is high
module mem_model (
   input  logic              clock_x,
   input  logic              rst_n_i,
   input  logic              stall_i,     // long back-pressure mode
   input  logic              mcb_ce_i,
   input  acq_pkg::mem_cmd_t mcb_cmd_i,
   output logic              mcb_rdy_o,
   output int unsigned       recv_cnt_o   // commands taken since reset
);

   import acq_pkg::*;

   logic        rdy      = 1'b0;
   int unsigned recv_cnt = 0;
   mem_cmd_t    log_q[$];   // every accepted command, in order

   assign mcb_rdy_o  = rdy;
   assign recv_cnt_o = recv_cnt;

   always @(posedge clock_x or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rdy      <= 1'b0;
         recv_cnt <= 0;
         log_q.delete();
      end else begin
         if (mcb_ce_i && rdy) begin
            log_q.push_back(mcb_cmd_i);  // transfer on this edge
            recv_cnt <= log_q.size();    // log length so far
         end
         rdy <= !stall_i && ($urandom_range(3) != 0);  // ready about 3 in 4
      end
   end

endmodule

// ==== bench/tb_acq_top.sv ====
`timescale 1ns/1ps

module tb_acq_top;

   import acq_pkg::*;

   localparam int TIMEOUT = 5000;  // cycles per wait

   logic        clock_x  = 1'b0;
   logic        rst_n_i;
   logic        capture_i;
   logic        request_i;
   logic        strobe_i = 1'b0;
   sample_t     signal_i = '0;
   logic        mcb_ce_o;
   logic        mcb_rdy_i;
   mem_cmd_t    mcb_cmd_o;
   acq_state_e  state_o;

   logic        stall;           // ready held low in mem_model
   int unsigned strobe_pct;      // strobe chance per cycle, percent
   int unsigned recv_cnt;
   sample_t     ref_q[$];        // samples still owed to the controller
   sample_t     exp_smp;
   mem_cmd_t    prev_cmd;
   logic        seen_cap;
   logic        armed;
   logic        held;            // command stalled at the last edge
   logic        done_due;
   logic        idle_due;
   int          exp_adr;
   int          cap_strobes;     // strobes since capture_i was taken
   int          errors     = 0;
   int          end_errors = 0;
   int          timeouts   = 0;

   always #5 clock_x = ~clock_x;

   acq_top dut_i (
      .clock_x   (clock_x),
      .rst_n_i   (rst_n_i),
      .capture_i (capture_i),
      .request_i (request_i),
      .strobe_i  (strobe_i),
      .signal_i  (signal_i),
      .mcb_ce_o  (mcb_ce_o),
      .mcb_rdy_i (mcb_rdy_i),
      .mcb_cmd_o (mcb_cmd_o),
      .state_o   (state_o)
   );

   mem_model u_mem (
      .clock_x    (clock_x),
      .rst_n_i    (rst_n_i),
      .stall_i    (stall),
      .mcb_ce_i   (mcb_ce_o),
      .mcb_cmd_i  (mcb_cmd_o),
      .mcb_rdy_o  (mcb_rdy_i),
      .recv_cnt_o (recv_cnt)
   );

   // random strobes and antenna bits
   always @(posedge clock_x) begin
      strobe_i <= ($urandom_range(99) < strobe_pct);
      signal_i <= sample_t'($urandom);
   end

   task automatic report_mismatch(input string sig, input logic [63:0] exp_v,
                                  input logic [63:0] got_v);
      errors++;
      $display("FAILED at %0t: %s expected %0h got %0h", $time, sig, exp_v, got_v);
   endtask

   // one-cycle pulse on capture_i or request_i
   task automatic pulse_control(input logic cap);
      @(posedge clock_x);
      capture_i <= cap;
      request_i <= !cap;
      @(posedge clock_x);
      capture_i <= 1'b0;
      request_i <= 1'b0;
   endtask

   task automatic wait_state(input acq_state_e target, input string what);
      int n = 0;
      while (state_o != target && n < TIMEOUT) begin
         @(posedge clock_x);
         n++;
      end
      if (state_o != target) begin
         timeouts++;
         $display("timeout: no %s within %0d cycles", what, TIMEOUT);
      end
   endtask

   // ------------------------------
   // checker, sees values from just before each edge
   // ------------------------------
   always @(posedge clock_x) begin
      if (!rst_n_i) begin
         ref_q.delete();
         seen_cap    = 1'b0;
         armed       = 1'b0;
         held        = 1'b0;
         done_due    = 1'b0;
         idle_due    = 1'b0;
         exp_adr     = 0;
         cap_strobes = 0;
      end else begin
         if (done_due)  // last word went out one edge ago
            assert (state_o == DONE) else report_mismatch("state_o", 64'(DONE), 64'(state_o));
         if (idle_due)
            assert (state_o == IDLE) else report_mismatch("state_o", 64'(IDLE), 64'(state_o));
         if (held && state_o != OVERFLOW) begin  // stalled command must not move
            assert (mcb_ce_o) else report_mismatch("mcb_ce_o", 64'(1), 64'(mcb_ce_o));
            assert (mcb_cmd_o == prev_cmd)
               else report_mismatch("mcb_cmd_o", 64'(prev_cmd), 64'(mcb_cmd_o));
         end
         assert (seen_cap || state_o == IDLE)
            else report_mismatch("state_o", 64'(IDLE), 64'(state_o));
         assert (state_o == CAPTURE || !mcb_ce_o)  // no requests outside CAPTURE
            else report_mismatch("mcb_ce_o", 64'(0), 64'(mcb_ce_o));
         done_due = 1'b0;
         idle_due = (state_o == DONE || state_o == OVERFLOW) && request_i;
         held     = mcb_ce_o && !mcb_rdy_i;
         prev_cmd = mcb_cmd_o;

         if (state_o == IDLE && capture_i) begin
            seen_cap    = 1'b1;
            armed       = 1'b1;
            exp_adr     = 0;   // every capture restarts at address 0
            cap_strobes = 0;
            ref_q.delete();
         end else if (armed && state_o == CAPTURE && strobe_i) begin
            cap_strobes++;
            if (cap_strobes <= CAPTURE_WORDS) ref_q.push_back(signal_i);
         end

         // 511 waiting plus the new strobe, up to two more held in read and command stages
         if (armed && state_o == OVERFLOW) begin
            armed = 1'b0;
            assert (cap_strobes >= BUF_DEPTH && (!stall || cap_strobes <= BUF_DEPTH + 2))
               else begin
                  errors++;
                  $display("overflow came after %0d strobes, outside the expected range",
                           cap_strobes);
               end
         end

         if (mcb_ce_o && mcb_rdy_i) begin
            assert (ref_q.size() != 0) else begin
               errors++;
               $display("command accepted at %0t with no sample owed", $time);
            end
            if (ref_q.size() != 0) begin
               exp_smp = ref_q.pop_front();
               assert (mcb_cmd_o.dat == 32'(exp_smp))
                  else report_mismatch("mcb_cmd_o.dat", 64'(exp_smp), 64'(mcb_cmd_o.dat));
            end
            assert (mcb_cmd_o.adr == MEM_AW'(exp_adr))
               else report_mismatch("mcb_cmd_o.adr", 64'(exp_adr), 64'(mcb_cmd_o.adr));
            exp_adr++;
            done_due = (exp_adr == CAPTURE_WORDS);
         end
      end
   end

   // ------------------------------
   // test sequence
   // ------------------------------
   initial begin
      void'($urandom(32'h689751b2));
      rst_n_i    = 1'b0;
      capture_i  = 1'b0;
      request_i  = 1'b0;
      stall      = 1'b0;
      strobe_pct = 40;
      repeat (10) @(posedge clock_x);
      rst_n_i <= 1'b1;
      repeat (20) @(posedge clock_x);  // strobes while idle, nothing goes out

      pulse_control(1'b1);  // capture under random ready
      wait_state(DONE, "DONE after the first capture");
      repeat (20) @(posedge clock_x);
      pulse_control(1'b0);
      wait_state(IDLE, "IDLE after request in DONE");

      stall      <= 1'b1;   // long stall, strobe every cycle
      strobe_pct <= 100;
      pulse_control(1'b1);
      wait_state(OVERFLOW, "OVERFLOW under a long stall");
      repeat (20) @(posedge clock_x);
      pulse_control(1'b0);
      wait_state(IDLE, "IDLE after request in OVERFLOW");

      stall      <= 1'b0;
      strobe_pct <= 40;
      pulse_control(1'b1);  // must start over at address 0
      wait_state(DONE, "DONE after the last capture");
      pulse_control(1'b0);
      wait_state(IDLE, "IDLE after the final request");
      repeat (5) @(posedge clock_x);

      // two full captures reach the controller, the stalled one sends nothing
      assert (recv_cnt == 32'(2 * CAPTURE_WORDS)) else begin
         end_errors++;
         $display("FAILED at %0t: recv_cnt expected %0d got %0d", $time,
                  2 * CAPTURE_WORDS, recv_cnt);
      end
      $display("check failures: %0d, timeouts: %0d", errors + end_errors, timeouts);
      if (errors == 0 && end_errors == 0 && timeouts == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// ==== files.f ====
verilog/acq_pkg.sv
verilog/sample_buffer.sv
verilog/burst_scheduler.sv
verilog/raw_acquire.sv
verilog/acq_top.sv
bench/mem_model.sv
bench/tb_acq_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the acquisition testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f files.f --top-module tb_acq_top -Mdir "$OBJ" -o vtb
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

"$OBJ"/vtb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

# the log decides the verdict
if grep -q "TESTBENCH FAILED" "$LOG"; then
   exit 1
fi
exit 0
